// File: design/spi_slave_params.svh
`ifndef SPI_SLAVE_PARAMS_SVH
`define SPI_SLAVE_PARAMS_SVH

// ==========================================================
// buffer sizing
// ==========================================================

// bytes held for the master to read out
`define SPI_TX_DEPTH 16

// received bytes waiting for upload
`define SPI_RX_DEPTH 16

// ==========================================================
// line fill
// ==========================================================

// shifted out when nothing is buffered
`define SPI_IDLE_BYTE 8'hFF

`endif

// File: design/spi_cmd_pkg.sv
package spi_cmd_pkg;

    // ==========================================================
    // command codes on the command bus
    // ==========================================================

    typedef enum logic [7:0] {
        CMD_SLAVE_WRITE = 8'h14,    // fill transmit buffer
        CMD_SLAVE_CTRL  = 8'h15     // control byte
    } spi_cmd_e;

    // ==========================================================
    // one command data byte, two views
    // ==========================================================

    // raw for write payload, fields for the control byte
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [5:0] reserved;
            logic       rx_flush;   // empty the receive queue
            logic       upload_en;  // upload on/off
        } ctrl;
    } slave_ctrl_u;

endpackage

// File: design/spi_link_pkg.sv
package spi_link_pkg;

    // ==========================================================
    // upload link source ids
    // ==========================================================

    // tag carried with every uploaded byte
    typedef enum logic [7:0] {
        SRC_SPI_SLAVE = 8'h14
    } upload_src_e;

endpackage

// File: design/spi_tx_buffer.sv
`include "spi_slave_params.svh"

module spi_tx_buffer import spi_cmd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // command bus
    input  spi_cmd_e    i_cmd_type,
    input  logic [15:0] i_cmd_length,
    input  slave_ctrl_u i_cmd_data,
    input  logic [15:0] i_cmd_data_index,
    input  logic        i_cmd_start,
    input  logic        i_cmd_data_valid,
    input  logic        i_cmd_done,
    output logic        o_cmd_ready,
    // read port for the handler
    input  logic [3:0]  i_tx_rd_addr,
    output logic [7:0]  o_tx_rd_data,
    // results to the handler
    output logic [4:0]  o_tx_len,
    output logic        o_tx_loaded,
    output logic        o_upload_en,
    output logic        o_rx_flush
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_COLLECT = 2'd1;
    localparam logic [1:0] ST_UPDATE  = 2'd2;

    logic [1:0] state;
    spi_cmd_e   cmd_q;
    logic [4:0] pend_len;
    logic       start_ok;
    logic       mem_we;
    logic [7:0] tx_mem [`SPI_TX_DEPTH];

    // ==========================================================
    // command acceptance
    // ==========================================================

    // write needs 1..depth bytes, control at least one
    always_comb begin
        case (i_cmd_type)
            CMD_SLAVE_WRITE: begin
                start_ok = (i_cmd_length != 16'd0) && (i_cmd_length <= `SPI_TX_DEPTH);
            end
            CMD_SLAVE_CTRL: begin
                start_ok = (i_cmd_length != 16'd0);
            end
            default: begin
                start_ok = 1'b0;
            end
        endcase
    end

    // ==========================================================
    // command FSM
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            cmd_q       <= CMD_SLAVE_WRITE;
            pend_len    <= '0;
            o_tx_len    <= '0;
            o_upload_en <= 1'b0;
            o_rx_flush  <= 1'b0;
        end else begin
            // flush is a single-cycle strobe
            o_rx_flush <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // unknown codes and bad lengths keep us here
                    if (i_cmd_start && start_ok) begin
                        cmd_q    <= i_cmd_type;
                        pend_len <= i_cmd_length[4:0];
                        state    <= ST_COLLECT;
                    end
                end
                ST_COLLECT: begin
                    // control byte sits at index 0, takes effect next cycle
                    if (i_cmd_data_valid && (cmd_q == CMD_SLAVE_CTRL) &&
                        (i_cmd_data_index == 16'd0)) begin
                        o_upload_en <= i_cmd_data.ctrl.upload_en;
                        o_rx_flush  <= i_cmd_data.ctrl.rx_flush;
                    end
                    if (i_cmd_done) begin
                        state <= (cmd_q == CMD_SLAVE_WRITE) ? ST_UPDATE : ST_IDLE;
                    end
                end
                ST_UPDATE: begin
                    // new length goes out with the load strobe
                    o_tx_len <= pend_len;
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ==========================================================
    // payload storage
    // ==========================================================

    assign mem_we = (state == ST_COLLECT) && i_cmd_data_valid &&
                    (cmd_q == CMD_SLAVE_WRITE) && (i_cmd_data_index < `SPI_TX_DEPTH);

    always_ff @(posedge clk) begin
        if (mem_we) begin
            tx_mem[i_cmd_data_index[3:0]] <= i_cmd_data.raw;
        end
    end

    assign o_tx_rd_data = tx_mem[i_tx_rd_addr];

    // busy only in the update cycle
    assign o_cmd_ready = (state != ST_UPDATE);
    assign o_tx_loaded = (state == ST_UPDATE);

endmodule

// File: design/spi_slave_phy.sv
`include "spi_slave_params.svh"

module spi_slave_phy (
    input  logic       clk,
    input  logic       rst_n,
    // SPI pins
    input  logic       i_spi_clk,
    input  logic       i_spi_cs_n,
    input  logic       i_spi_mosi,
    output logic       o_spi_miso,
    // byte interface
    input  logic [7:0] i_tx_byte,
    output logic [7:0] o_rx_byte,
    output logic       o_byte_done,
    output logic       o_frame_start
);

    localparam logic [7:0] IDLE_BYTE = `SPI_IDLE_BYTE;

    logic [2:0] sclk_sync;
    logic [2:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_fall;
    logic       cs_active;
    logic       rx_bit_en;
    logic [2:0] bit_cnt;
    logic       reload;
    logic [7:0] tx_shift;
    logic [7:0] rx_shift;

    // ==========================================================
    // pin synchronizers
    // ==========================================================

    // two flops each, third stage for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= 3'b000;
            cs_sync   <= 3'b111;
            mosi_sync <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], i_spi_clk};
            cs_sync   <= {cs_sync[1:0], i_spi_cs_n};
            mosi_sync <= {mosi_sync[0], i_spi_mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_fall   = cs_sync[2] & ~cs_sync[1];
    assign cs_active = ~cs_sync[1];

    // mosi sampling point, mode 0
    assign rx_bit_en = cs_active && !cs_fall && sclk_rise;

    // ==========================================================
    // bit counter and transmit shifter
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt       <= 3'd0;
            reload        <= 1'b0;
            tx_shift      <= IDLE_BYTE;
            o_byte_done   <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            o_byte_done   <= 1'b0;
            o_frame_start <= 1'b0;
            if (cs_fall) begin
                // first byte must be on the line before the first rise
                tx_shift      <= i_tx_byte;
                bit_cnt       <= 3'd0;
                reload        <= 1'b0;
                o_frame_start <= 1'b1;
            end else if (!cs_active) begin
                // partial byte dropped
                bit_cnt <= 3'd0;
                reload  <= 1'b0;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        o_byte_done <= 1'b1;
                        reload      <= 1'b1;
                    end
                end
                if (sclk_fall) begin
                    // next byte on the fall after a completed byte
                    if (reload) begin
                        tx_shift <= i_tx_byte;
                        reload   <= 1'b0;
                    end else begin
                        tx_shift <= {tx_shift[6:0], 1'b1};
                    end
                end
            end
        end
    end

    // ==========================================================
    // receive shifter
    // ==========================================================

    // msb first
    always_ff @(posedge clk) begin
        if (rx_bit_en) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                o_rx_byte <= {rx_shift[6:0], mosi_sync[1]};
            end
        end
    end

    // delayed cs stage lines up with the shifter load
    assign o_spi_miso = cs_sync[2] ? IDLE_BYTE[7] : tx_shift[7];

endmodule

// File: design/spi_slave_handler.sv
`include "spi_slave_params.svh"

module spi_slave_handler import spi_link_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // from the transmit buffer
    input  logic [4:0]  i_tx_len,
    input  logic        i_tx_loaded,
    input  logic [7:0]  i_tx_rd_data,
    input  logic        i_upload_en,
    input  logic        i_rx_flush,
    output logic [3:0]  o_tx_rd_addr,
    // serial engine
    input  logic [7:0]  i_rx_byte,
    input  logic        i_byte_done,
    input  logic        i_frame_start,
    output logic [7:0]  o_tx_byte,
    // upload port
    input  logic        i_upload_ready,
    output logic        o_upload_valid,
    output logic [7:0]  o_upload_data,
    output upload_src_e o_upload_source,
    output logic        o_upload_active
);

    localparam int         RX_AW     = $clog2(`SPI_RX_DEPTH);
    localparam logic [7:0] IDLE_BYTE = `SPI_IDLE_BYTE;
    localparam logic       UP_IDLE   = 1'b0;
    localparam logic       UP_GAP    = 1'b1;

    logic [4:0]     tx_ptr;
    logic           tx_fetch;
    logic [7:0]     rx_mem [`SPI_RX_DEPTH];
    logic [RX_AW:0] rx_wr_ptr;
    logic [RX_AW:0] rx_rd_ptr;
    logic           rx_empty;
    logic           rx_full;
    logic           rx_push;
    logic           rx_pop;
    logic           up_state;

    // ==========================================================
    // transmit pointer
    // ==========================================================

    // saturates at the length, no rewind at frame end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_ptr    <= '0;
            tx_fetch  <= 1'b0;
            o_tx_byte <= IDLE_BYTE;
        end else begin
            if (i_tx_loaded) begin
                tx_ptr <= '0;
            end else if (i_byte_done && (tx_ptr < i_tx_len)) begin
                tx_ptr <= tx_ptr + 5'd1;
            end
            // refetch once the pointer has settled
            tx_fetch <= i_tx_loaded | i_byte_done | i_frame_start;
            if (tx_fetch) begin
                o_tx_byte <= (tx_ptr < i_tx_len) ? i_tx_rd_data : IDLE_BYTE;
            end
        end
    end

    assign o_tx_rd_addr = tx_ptr[3:0];

    // ==========================================================
    // receive queue
    // ==========================================================

    // extra pointer bit tells full from empty
    assign rx_empty = (rx_wr_ptr == rx_rd_ptr);
    assign rx_full  = (rx_wr_ptr[RX_AW] != rx_rd_ptr[RX_AW]) &&
                      (rx_wr_ptr[RX_AW-1:0] == rx_rd_ptr[RX_AW-1:0]);
    assign rx_push  = i_byte_done && !rx_full;
    assign rx_pop   = (up_state == UP_IDLE) && i_upload_en && !rx_empty &&
                      i_upload_ready && !i_rx_flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
        end else if (i_rx_flush) begin
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
        end else begin
            if (rx_push) begin
                rx_wr_ptr <= rx_wr_ptr + 1'b1;
            end
            if (rx_pop) begin
                rx_rd_ptr <= rx_rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_push) begin
            rx_mem[rx_wr_ptr[RX_AW-1:0]] <= i_rx_byte;
        end
        if (rx_pop) begin
            o_upload_data <= rx_mem[rx_rd_ptr[RX_AW-1:0]];
        end
    end

    // ==========================================================
    // upload sequencer
    // ==========================================================

    // strobe, then one idle cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_state       <= UP_IDLE;
            o_upload_valid <= 1'b0;
        end else begin
            case (up_state)
                UP_IDLE: begin
                    if (rx_pop) begin
                        o_upload_valid <= 1'b1;
                        up_state       <= UP_GAP;
                    end
                end
                default: begin
                    o_upload_valid <= 1'b0;
                    up_state       <= UP_IDLE;
                end
            endcase
        end
    end

    assign o_upload_source = SRC_SPI_SLAVE;
    assign o_upload_active = i_upload_en && !rx_empty;

endmodule

// File: design/spi_slave_top.sv
module spi_slave_top import spi_cmd_pkg::*, spi_link_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // command bus
    input  spi_cmd_e    i_cmd_type,
    input  logic [15:0] i_cmd_length,
    input  slave_ctrl_u i_cmd_data,
    input  logic [15:0] i_cmd_data_index,
    input  logic        i_cmd_start,
    input  logic        i_cmd_data_valid,
    input  logic        i_cmd_done,
    output logic        o_cmd_ready,
    // SPI pins
    input  logic        i_spi_clk,
    input  logic        i_spi_cs_n,
    input  logic        i_spi_mosi,
    output logic        o_spi_miso,
    // upload port
    input  logic        i_upload_ready,
    output logic        o_upload_valid,
    output logic [7:0]  o_upload_data,
    output upload_src_e o_upload_source,
    output logic        o_upload_active
);

    // buffer to handler
    logic [3:0] tx_rd_addr;
    logic [7:0] tx_rd_data;
    logic [4:0] tx_len;
    logic       tx_loaded;
    logic       upload_en;
    logic       rx_flush;
    // engine to handler
    logic [7:0] rx_byte;
    logic       byte_done;
    logic       frame_start;
    logic [7:0] tx_byte;

    // ==========================================================
    // command side
    // ==========================================================

    spi_tx_buffer u_tx_buffer (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cmd_type       (i_cmd_type),
        .i_cmd_length     (i_cmd_length),
        .i_cmd_data       (i_cmd_data),
        .i_cmd_data_index (i_cmd_data_index),
        .i_cmd_start      (i_cmd_start),
        .i_cmd_data_valid (i_cmd_data_valid),
        .i_cmd_done       (i_cmd_done),
        .o_cmd_ready      (o_cmd_ready),
        .i_tx_rd_addr     (tx_rd_addr),
        .o_tx_rd_data     (tx_rd_data),
        .o_tx_len         (tx_len),
        .o_tx_loaded      (tx_loaded),
        .o_upload_en      (upload_en),
        .o_rx_flush       (rx_flush)
    );

    // ==========================================================
    // serial engine
    // ==========================================================

    spi_slave_phy u_phy (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_spi_clk     (i_spi_clk),
        .i_spi_cs_n    (i_spi_cs_n),
        .i_spi_mosi    (i_spi_mosi),
        .o_spi_miso    (o_spi_miso),
        .i_tx_byte     (tx_byte),
        .o_rx_byte     (rx_byte),
        .o_byte_done   (byte_done),
        .o_frame_start (frame_start)
    );

    // ==========================================================
    // handler
    // ==========================================================

    spi_slave_handler u_handler (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_tx_len        (tx_len),
        .i_tx_loaded     (tx_loaded),
        .i_tx_rd_data    (tx_rd_data),
        .i_upload_en     (upload_en),
        .i_rx_flush      (rx_flush),
        .o_tx_rd_addr    (tx_rd_addr),
        .i_rx_byte       (rx_byte),
        .i_byte_done     (byte_done),
        .i_frame_start   (frame_start),
        .o_tx_byte       (tx_byte),
        .i_upload_ready  (i_upload_ready),
        .o_upload_valid  (o_upload_valid),
        .o_upload_data   (o_upload_data),
        .o_upload_source (o_upload_source),
        .o_upload_active (o_upload_active)
    );

endmodule

// File: tb/tb_clkgen.sv
module tb_clkgen (
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // free running, 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

endmodule

// File: tb/spi_slave_asserts.sv
module spi_slave_asserts (
    input logic clk,
    input logic rst_n,
    input logic i_spi_cs_n,
    input logic o_spi_miso,
    input logic i_upload_ready,
    input logic o_upload_valid,
    input logic o_cmd_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // ==========================================================
    // upload port
    // ==========================================================

    // strobe, then at least one idle cycle
    a_upload_gap: assert property (@(posedge clk) disable iff (!rst_n)
        o_upload_valid |=> !o_upload_valid)
        else $error("o_upload_valid high in two consecutive cycles");

    // pop decision needs ready one cycle earlier
    a_upload_ready: assert property (@(posedge clk) disable iff (!rst_n)
        o_upload_valid |-> $past(i_upload_ready))
        else $error("o_upload_valid without i_upload_ready in the cycle before");

    // ==========================================================
    // SPI and command bus
    // ==========================================================

    // driven line while selected
    a_miso_known: assert property (@(posedge clk) disable iff (!rst_n)
        !i_spi_cs_n |-> !$isunknown(o_spi_miso))
        else $error("o_spi_miso unknown while i_spi_cs_n is low");

    // busy only for the update cycle
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !o_cmd_ready |=> o_cmd_ready)
        else $error("o_cmd_ready low for more than one cycle");

endmodule

bind spi_slave_top spi_slave_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_spi_cs_n     (i_spi_cs_n),
    .o_spi_miso     (o_spi_miso),
    .i_upload_ready (i_upload_ready),
    .o_upload_valid (o_upload_valid),
    .o_cmd_ready    (o_cmd_ready)
);

// File: tb/spi_slave_tb.sv
`include "spi_slave_params.svh"

module spi_slave_tb import spi_cmd_pkg::*, spi_link_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam string       PATTERN_FILE  = "tb/spi_slave_patterns.txt";
    localparam logic [31:0] LCG_SEED      = 32'h2b58eae6;
    localparam int          CYCLES_PER_OP = 1200;
    localparam int          HALF_SCLK     = 4;
    // source id tagged onto every upload
    localparam logic [7:0]  UPLOAD_SRC_ID = 8'h14;

    logic        clk;
    logic        rst_n;
    spi_cmd_e    cmd_type;
    logic [15:0] cmd_length;
    slave_ctrl_u cmd_data;
    logic [15:0] cmd_index;
    logic        cmd_start;
    logic        cmd_valid;
    logic        cmd_done;
    logic        cmd_ready;
    logic        spi_clk;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    logic        upload_ready;
    logic        upload_valid;
    logic [7:0]  upload_data;
    upload_src_e upload_source;
    logic        upload_active;

    // bytes sent on MOSI that still await upload
    logic [7:0]  model_q[$];
    // captured uploads as {source, data}
    logic [15:0] got_q[$];
    logic [7:0]  cmd_bytes[$];
    logic [7:0]  mosi_q[$];
    logic [7:0]  miso_q[$];
    logic [31:0] lcg_state;
    int          fd;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;

    tb_clkgen u_clkgen (
        .o_clk (clk)
    );

    spi_slave_top u_spi_slave_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cmd_type       (cmd_type),
        .i_cmd_length     (cmd_length),
        .i_cmd_data       (cmd_data),
        .i_cmd_data_index (cmd_index),
        .i_cmd_start      (cmd_start),
        .i_cmd_data_valid (cmd_valid),
        .i_cmd_done       (cmd_done),
        .o_cmd_ready      (cmd_ready),
        .i_spi_clk        (spi_clk),
        .i_spi_cs_n       (spi_cs_n),
        .i_spi_mosi       (spi_mosi),
        .o_spi_miso       (spi_miso),
        .i_upload_ready   (upload_ready),
        .o_upload_valid   (upload_valid),
        .o_upload_data    (upload_data),
        .o_upload_source  (upload_source),
        .o_upload_active  (upload_active)
    );

    // ==========================================================
    // helpers
    // ==========================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic read_hex(output logic [31:0] v);
        if ($fscanf(fd, "%h", v) != 1) begin
            abort_run("pattern file ends in the middle of an operation");
        end
    endtask

    // captures uploads with the previous-cycle values at the rising edge
    always @(posedge clk) begin
        if (rst_n && upload_valid) begin
            got_q.push_back({upload_source, upload_data});
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
            abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    // ==========================================================
    // command bus and SPI master
    // ==========================================================

    task automatic wait_cmd_ready();
        while (!cmd_ready) @(negedge clk);
    endtask

    // start strobe, one data strobe per byte in cmd_bytes, then done
    task automatic send_command(input spi_cmd_e code, input logic [15:0] len);
        logic accepted;
        // only a write of 1 to depth bytes reaches the update cycle
        accepted = (code == CMD_SLAVE_WRITE) && (len >= 16'd1) &&
                   (len <= `SPI_TX_DEPTH);
        wait_cmd_ready();
        cmd_type   = code;
        cmd_length = len;
        cmd_start  = 1'b1;
        @(negedge clk);
        cmd_start = 1'b0;
        for (int i = 0; i < cmd_bytes.size(); i++) begin
            wait_cmd_ready();
            cmd_index    = i[15:0];
            cmd_data.raw = cmd_bytes[i];
            cmd_valid    = 1'b1;
            @(negedge clk);
            cmd_valid = 1'b0;
        end
        wait_cmd_ready();
        cmd_done = 1'b1;
        @(negedge clk);
        cmd_done = 1'b0;
        // busy for exactly the cycle after done
        compare_value("o_cmd_ready", cmd_ready, accepted ? 32'd0 : 32'd1);
        wait_cycles(1);
        compare_value("o_cmd_ready", cmd_ready, 32'd1);
        wait_cycles(1);
    endtask

    // mode 0 frame that shifts mosi_q out and expects miso_q back
    task automatic run_frame();
        logic [7:0] rx;
        rx       = 8'h00;
        spi_cs_n = 1'b0;
        for (int b = 0; b < mosi_q.size(); b++) begin
            for (int i = 7; i >= 0; i--) begin
                spi_mosi = mosi_q[b][i];
                wait_cycles(HALF_SCLK);
                // master samples just before the rise
                rx      = {rx[6:0], spi_miso};
                spi_clk = 1'b1;
                wait_cycles(HALF_SCLK);
                spi_clk = 1'b0;
            end
            compare_value("o_spi_miso", rx, miso_q[b]);
            // full queue drops the byte
            if ((int'(model_q.size()) - int'(got_q.size())) < `SPI_RX_DEPTH) begin
                model_q.push_back(mosi_q[b]);
            end
        end
        wait_cycles(HALF_SCLK);
        spi_cs_n = 1'b1;
        wait_cycles(2 * HALF_SCLK);
    endtask

    // ==========================================================
    // upload checks
    // ==========================================================

    task automatic hold_idle(input logic [31:0] n, input logic active);
        repeat (n) begin
            @(negedge clk);
            compare_value("o_upload_valid", upload_valid, 32'd0);
            compare_value("o_upload_active", upload_active, active);
        end
    endtask

    task automatic expect_uploads(input logic [31:0] n);
        logic [15:0] got;
        logic [7:0]  exp;
        if (model_q.size() < n) begin
            abort_run("pattern expects more uploads than bytes were queued");
        end
        while (got_q.size() < n) @(negedge clk);
        repeat (n) begin
            got = got_q.pop_front();
            exp = model_q.pop_front();
            compare_value("o_upload_source", got[15:8], UPLOAD_SRC_ID);
            compare_value("o_upload_data", got[7:0], exp);
        end
        // nothing more may follow
        wait_cycles(24);
        compare_value("extra upload count", got_q.size(), 32'd0);
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================

    initial begin
        logic [7:0]          op;
        logic [8*256-1:0]    rest;
        logic [31:0]         n;
        logic [31:0]         v;
        logic [31:0]         w;
        int                  ops;

        rst_n        = 1'b0;
        cmd_type     = CMD_SLAVE_WRITE;
        cmd_length   = 16'd0;
        cmd_data.raw = 8'h00;
        cmd_index    = 16'd0;
        cmd_start    = 1'b0;
        cmd_valid    = 1'b0;
        cmd_done     = 1'b0;
        spi_clk      = 1'b0;
        spi_cs_n     = 1'b1;
        spi_mosi     = 1'b0;
        upload_ready = 1'b1;
        lcg_state    = LCG_SEED;

        // count operations for the run limit
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the pattern file");
        end
        ops = 0;
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op != "#") begin
                ops++;
            end
            void'($fgets(rest, fd));
        end
        $fclose(fd);
        cycle_limit = ops * CYCLES_PER_OP;

        wait_cycles(3);
        rst_n = 1'b1;
        wait_cycles(2);

        fd = $fopen(PATTERN_FILE, "r");
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": begin
                    void'($fgets(rest, fd));
                end
                "W": begin
                    read_hex(n);
                    cmd_bytes.delete();
                    repeat (n) begin
                        read_hex(v);
                        cmd_bytes.push_back(v[7:0]);
                    end
                    send_command(CMD_SLAVE_WRITE, n[15:0]);
                end
                "C": begin
                    read_hex(v);
                    cmd_bytes.delete();
                    cmd_bytes.push_back(v[7:0]);
                    send_command(CMD_SLAVE_CTRL, 16'd1);
                    // flush bit empties the queue
                    if (v[1]) begin
                        model_q.delete();
                    end
                end
                "F": begin
                    read_hex(n);
                    mosi_q.delete();
                    miso_q.delete();
                    repeat (n) begin
                        read_hex(v);
                        read_hex(w);
                        mosi_q.push_back(v[7:0]);
                        miso_q.push_back(w[7:0]);
                    end
                    run_frame();
                end
                "R": begin
                    read_hex(n);
                    read_hex(w);
                    mosi_q.delete();
                    miso_q.delete();
                    repeat (n) begin
                        lcg_state = lcg_next(lcg_state);
                        mosi_q.push_back(lcg_state[23:16]);
                        miso_q.push_back(w[7:0]);
                    end
                    run_frame();
                end
                "Y": begin
                    read_hex(v);
                    upload_ready = v[0];
                    wait_cycles(1);
                end
                "H": begin
                    read_hex(n);
                    read_hex(v);
                    hold_idle(n, v[0]);
                end
                "U": begin
                    read_hex(n);
                    expect_uploads(n);
                end
                default: begin
                    abort_run($sformatf("unknown operation %c in the pattern file", op));
                end
            endcase
        end
        $fclose(fd);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: tb/spi_slave_patterns.txt
# one operation per line, all numbers hex
# W len data.. | C ctrl | F n (mosi miso).. | R n miso | Y ready | H cycles active | U count
W 0
F 1 a5 ff
W 4 11 22 33 44
F 2 31 11 32 22
W 11 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
F 3 33 33 34 44 35 ff
H 28 0
C 01
U 6
Y 0
F 2 41 ff 42 ff
H 3c 1
Y 1
U 2
C 00
R 14 ff
C 01
U 10
C 00
F 3 51 ff 52 ff 53 ff
C 02
C 01
H 3c 0

// File: tb.f
+incdir+design
design/spi_cmd_pkg.sv
design/spi_link_pkg.sv
design/spi_tx_buffer.sv
design/spi_slave_phy.sv
design/spi_slave_handler.sv
design/spi_slave_top.sv
tb/tb_clkgen.sv
tb/spi_slave_asserts.sv
tb/spi_slave_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := spi_slave_tb
FILELIST  := tb.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard design/*.svh)
PATTERNS  := tb/spi_slave_patterns.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(PATTERNS)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
